// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing -j 0
TOP = tb_cpu_core
FILELIST = verilog.f
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== decode.hex ====
// one microcode word per opcode, the index is instr[31:27]
8060
8061
8042
8043
8044
8045
8046
8070
8071
8021
c057
e058
a400
a480
a500
a580
a600
a680
bc40
0000
0000
0000
0000
0000
0000
0000
0000
0000
0000
0000
0000
0000

// ==== verif/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
	output logic clk
);

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

endmodule

// ==== verif/tb_cpu_core.sv ====
`timescale 1ns/100ps

module tb_cpu_core import cpu_pkg::*; ();

	localparam int reset_cycles = 16;
	localparam int n_random = 64; // 16 constant loads plus 48 alu operations
	localparam int max_rows = 32;
	localparam logic [31:0] seed_init = 32'hcbaef537;

	logic clk;
	logic rst;
	logic instr_valid;
	logic [31:0] instr;
	logic [31:0] pc;
	logic wb_valid;
	logic [3:0] wb_rd;
	logic [31:0] wb_data;
	logic branch_taken;
	logic [31:0] branch_target;
	logic illegal;
	logic [31:0] illegal_pc;
	logic [3:0] flags;

	string row_name [max_rows];
	logic [31:0] row_instr [max_rows];
	logic [31:0] row_pc [max_rows];
	logic row_has_wb [max_rows];
	logic [3:0] row_rd [max_rows];
	logic [31:0] row_data [max_rows];
	logic row_has_br [max_rows];
	logic [31:0] row_target [max_rows];
	logic row_has_ill [max_rows];
	logic row_has_flags [max_rows];
	logic [3:0] row_flags [max_rows];
	int n_rows = 0;

	// expected events, each with the cycle at which it must show up
	int wb_due_q [$];
	logic [3:0] wb_rd_q [$];
	logic [31:0] wb_data_q [$];
	string wb_name_q [$];
	int br_due_q [$];
	logic [31:0] br_target_q [$];
	string br_name_q [$];
	int ill_due_q [$];
	logic [31:0] ill_pc_q [$];
	string ill_name_q [$];
	int fl_due_q [$];
	logic [3:0] fl_val_q [$];
	string fl_name_q [$];

	logic [31:0] model_regs [16];
	logic [31:0] seed;
	logic [31:0] next_pc;
	int cycle = 0;
	int limit = 0;
	int check_errors = 0;
	int event_errors = 0;

	tb_clock clock_inst (.clk(clk));

	cpu_core cpu_core_inst (
		.clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr), .pc(pc),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
		.branch_taken(branch_taken), .branch_target(branch_target),
		.illegal(illegal), .illegal_pc(illegal_pc), .flags(flags)
	);

	function automatic logic [31:0] reg_form(input logic [4:0] op, input logic [3:0] rd,
						input logic [3:0] ra, input logic [3:0] rb);
		return {op, 15'b0, ra, rb, rd};
	endfunction

	function automatic logic [31:0] imm_form(input logic [4:0] op, input logic [3:0] rd,
						input logic [3:0] ra, input logic [12:0] imm);
		return {op, 2'b0, imm, ra, 4'b0, rd};
	endfunction

	function automatic logic [31:0] half_form(input logic [4:0] op, input logic [3:0] rd,
						input logic [15:0] half);
		return {op, half, 7'b0, rd};
	endfunction

	function automatic logic [31:0] branch_form(input logic [4:0] op, input logic [23:0] off);
		return {op, 3'b0, off}; // word offset from pc + 4
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// sequential result of one alu instruction, b is already the immediate for i-forms
	function automatic logic [31:0] model_alu(input logic [4:0] op, input logic [31:0] a,
						input logic [31:0] b);
		case (op)
		op_add, op_addi: return a + b;
		op_sub, op_subi: return a - b;
		op_and: return a & b;
		op_or: return a | b;
		op_xor: return a ^ b;
		op_shl: return a << b[4:0];
		op_shr: return a >> b[4:0];
		default: return 32'b0;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
				input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Error: %s expected %h actual %h", name, expected, actual);
			check_errors++;
		end
	endtask

	task automatic add_row(input string name, input logic [31:0] word, input logic has_wb,
			input logic [3:0] rd, input logic [31:0] data, input logic has_br,
			input logic [31:0] target, input logic has_ill);
		row_name[n_rows] = name;
		row_instr[n_rows] = word;
		row_pc[n_rows] = 32'h100 + 32'(n_rows * 4);
		row_has_wb[n_rows] = has_wb;
		row_rd[n_rows] = rd;
		row_data[n_rows] = data;
		row_has_br[n_rows] = has_br;
		row_target[n_rows] = target;
		row_has_ill[n_rows] = has_ill;
		row_has_flags[n_rows] = 1'b0;
		row_flags[n_rows] = 4'b0;
		n_rows++;
	endtask

	task automatic add_wb(input string name, input logic [31:0] word, input logic [3:0] rd,
			input logic [31:0] data);
		add_row(name, word, 1'b1, rd, data, 1'b0, 32'b0, 1'b0);
	endtask

	task automatic add_branch(input string name, input logic [31:0] word, input logic taken,
				input logic [31:0] target);
		add_row(name, word, 1'b0, 4'd0, 32'b0, taken, target, 1'b0);
	endtask

	// a compare only changes the flag word, written as {v, c, n, z}
	task automatic add_cmp(input string name, input logic [31:0] word,
			input logic [3:0] flag_val);
		add_row(name, word, 1'b0, 4'd0, 32'b0, 1'b0, 32'b0, 1'b0);
		row_has_flags[n_rows-1] = 1'b1;
		row_flags[n_rows-1] = flag_val;
	endtask

	// pcs run from 0x100 in steps of 4, the targets below depend on that
	task automatic build_table();
		add_wb("movhi r1", half_form(op_movhi, 4'd1, 16'h1234), 4'd1, 32'h12340000);
		add_wb("orlo r1", half_form(op_orlo, 4'd1, 16'h5678), 4'd1, 32'h12345678);
		add_wb("movhi r2", half_form(op_movhi, 4'd2, 16'hffff), 4'd2, 32'hffff0000);
		add_wb("orlo r2", half_form(op_orlo, 4'd2, 16'hfffe), 4'd2, 32'hfffffffe);
		add_wb("add r3", reg_form(op_add, 4'd3, 4'd1, 4'd2), 4'd3, 32'h12345676);
		add_wb("addi r4", imm_form(op_addi, 4'd4, 4'd3, 13'h1ffb), 4'd4, 32'h12345671);
		add_wb("subi r5", imm_form(op_subi, 4'd5, 4'd4, 13'h1ff0), 4'd5, 32'h12345681);
		add_wb("sub r6", reg_form(op_sub, 4'd6, 4'd5, 4'd3), 4'd6, 32'h0000000b);
		add_cmp("cmp equal", reg_form(op_cmp, 4'd0, 4'd1, 4'd1), 4'b0101);
		add_branch("beq", branch_form(op_beq, 24'h000003), 1'b1, 32'h00000134);
		add_branch("bne", branch_form(op_bne, 24'hfffffe), 1'b0, 32'b0);
		add_cmp("cmp less", reg_form(op_cmp, 4'd0, 4'd2, 4'd1), 4'b0110);
		add_branch("blt", branch_form(op_blt, 24'hfffff8), 1'b1, 32'h00000114);
		add_branch("bge", branch_form(op_bge, 24'h000005), 1'b0, 32'b0);
		add_branch("bult", branch_form(op_bult, 24'h000001), 1'b0, 32'b0);
		add_cmp("cmp borrow", reg_form(op_cmp, 4'd0, 4'd1, 4'd2), 4'b0000);
		add_branch("bult borrow", branch_form(op_bult, 24'h000002), 1'b1, 32'h0000014c);
		add_branch("bge back", branch_form(op_bge, 24'hffffff), 1'b1, 32'h00000144);
		add_branch("b", branch_form(op_b, 24'h000010), 1'b1, 32'h0000018c);
		add_row("call", branch_form(op_call, 24'hffffed), 1'b1, 4'd15, 32'h00000150,
			1'b1, 32'h00000104, 1'b0);
		add_row("illegal", reg_form(5'd25, 4'd6, 4'd1, 4'd2), 1'b0, 4'd0, 32'b0,
			1'b0, 32'b0, 1'b1);
		add_wb("add r7", reg_form(op_add, 4'd7, 4'd6, 4'd0), 4'd7, 32'h0000000b);
		add_wb("xor r8", reg_form(op_xor, 4'd8, 4'd15, 4'd1), 4'd8, 32'h12345728);
		add_wb("shl r9", reg_form(op_shl, 4'd9, 4'd6, 4'd6), 4'd9, 32'h00005800);
		add_wb("shr r10", reg_form(op_shr, 4'd10, 4'd1, 4'd6), 4'd10, 32'h0002468a);
		add_wb("and r11", reg_form(op_and, 4'd11, 4'd1, 4'd2), 4'd11, 32'h12345678);
		add_wb("or r12", reg_form(op_or, 4'd12, 4'd6, 4'd9), 4'd12, 32'h0000580b);
	endtask

	// drives one instruction and queues what it must produce
	task automatic issue_instr(input string name, input logic [31:0] word,
			input logic [31:0] pc_val, input logic has_wb, input logic [3:0] rd,
			input logic [31:0] data, input logic has_br, input logic [31:0] target,
			input logic has_ill, input logic has_flags, input logic [3:0] flag_val);
		int accept;
		@(posedge clk);
		instr <= word;
		pc <= pc_val;
		instr_valid <= 1'b1;
		accept = cycle + 1; // edge that presents this instruction to decode
		if (has_wb) begin
			wb_due_q.push_back(accept + 3);
			wb_rd_q.push_back(rd);
			wb_data_q.push_back(data);
			wb_name_q.push_back(name);
		end
		if (has_br) begin
			br_due_q.push_back(accept + 2);
			br_target_q.push_back(target);
			br_name_q.push_back(name);
		end
		if (has_ill) begin
			ill_due_q.push_back(accept + 3);
			ill_pc_q.push_back(pc_val);
			ill_name_q.push_back(name);
		end
		if (has_flags) begin
			fl_due_q.push_back(accept + 2);
			fl_val_q.push_back(flag_val);
			fl_name_q.push_back(name);
		end
	endtask

	task automatic run_random();
		logic [31:0] word;
		logic [31:0] b;
		logic [3:0] rd;
		logic [3:0] ra;
		logic [3:0] rb;
		logic [4:0] op;
		int pick;
		for (int i = 1; i <= 8; i++) begin
			seed = xorshift(seed);
			rd = 4'(i);
			model_regs[rd] = {seed[31:16], 16'b0};
			word = half_form(op_movhi, rd, seed[31:16]);
			issue_instr($sformatf("load hi r%0d", i), word, next_pc, 1'b1, rd,
				model_regs[rd], 1'b0, 32'b0, 1'b0, 1'b0, 4'b0);
			next_pc += 32'd4;
			model_regs[rd] = model_regs[rd] | {16'b0, seed[15:0]};
			word = half_form(op_orlo, rd, seed[15:0]);
			issue_instr($sformatf("load lo r%0d", i), word, next_pc, 1'b1, rd,
				model_regs[rd], 1'b0, 32'b0, 1'b0, 1'b0, 4'b0);
			next_pc += 32'd4;
		end
		// only r1..r6 are used so dependencies at distance one to three are frequent
		for (int i = 0; i < n_random - 16; i++) begin
			seed = xorshift(seed);
			pick = int'(seed % 32'd9);
			op = (pick < 7) ? 5'(pick) : ((pick == 7) ? op_addi : op_subi);
			rd = 4'd1 + ({1'b0, seed[10:8]} % 4'd6);
			ra = 4'd1 + ({1'b0, seed[14:12]} % 4'd6);
			rb = 4'd1 + ({1'b0, seed[18:16]} % 4'd6);
			if (pick < 7) begin
				word = reg_form(op, rd, ra, rb);
				b = model_regs[rb];
			end else begin
				word = imm_form(op, rd, ra, seed[31:19]);
				b = {{19{seed[31]}}, seed[31:19]};
			end
			model_regs[rd] = model_alu(op, model_regs[ra], b);
			issue_instr($sformatf("random %0d", i), word, next_pc, 1'b1, rd,
				model_regs[rd], 1'b0, 32'b0, 1'b0, 1'b0, 4'b0);
			next_pc += 32'd4;
		end
	endtask

	always @(posedge clk)
		cycle <= cycle + 1;

	// compare every observed event against the front of its queue
	always @(negedge clk) begin
		if (!rst) begin
			if (wb_due_q.size() > 0 && wb_due_q[0] < cycle) begin
				$display("missing register write for %s", wb_name_q[0]);
				event_errors++;
				void'(wb_due_q.pop_front());
				void'(wb_rd_q.pop_front());
				void'(wb_data_q.pop_front());
				void'(wb_name_q.pop_front());
			end
			if (wb_valid) begin
				if (wb_due_q.size() == 0 || wb_due_q[0] != cycle) begin
					$display("unexpected write to r%0d at cycle %0d", wb_rd, cycle);
					event_errors++;
				end else begin
					check_value({wb_name_q[0], " rd"}, {28'b0, wb_rd_q[0]}, {28'b0, wb_rd});
					check_value({wb_name_q[0], " data"}, wb_data_q[0], wb_data);
					void'(wb_due_q.pop_front());
					void'(wb_rd_q.pop_front());
					void'(wb_data_q.pop_front());
					void'(wb_name_q.pop_front());
				end
			end
			if (br_due_q.size() > 0 && br_due_q[0] < cycle) begin
				$display("branch %s was not taken", br_name_q[0]);
				event_errors++;
				void'(br_due_q.pop_front());
				void'(br_target_q.pop_front());
				void'(br_name_q.pop_front());
			end
			if (branch_taken) begin
				if (br_due_q.size() == 0 || br_due_q[0] != cycle) begin
					$display("unexpected taken branch at cycle %0d", cycle);
					event_errors++;
				end else begin
					check_value({br_name_q[0], " target"}, br_target_q[0], branch_target);
					void'(br_due_q.pop_front());
					void'(br_target_q.pop_front());
					void'(br_name_q.pop_front());
				end
			end
			if (ill_due_q.size() > 0 && ill_due_q[0] < cycle) begin
				$display("no illegal report for %s", ill_name_q[0]);
				event_errors++;
				void'(ill_due_q.pop_front());
				void'(ill_pc_q.pop_front());
				void'(ill_name_q.pop_front());
			end
			if (illegal) begin
				if (ill_due_q.size() == 0 || ill_due_q[0] != cycle) begin
					$display("unexpected illegal report at cycle %0d", cycle);
					event_errors++;
				end else begin
					check_value({ill_name_q[0], " pc"}, ill_pc_q[0], illegal_pc);
					void'(ill_due_q.pop_front());
					void'(ill_pc_q.pop_front());
					void'(ill_name_q.pop_front());
				end
			end
			// flags settle in the same cycle as a branch decision would
			if (fl_due_q.size() > 0 && fl_due_q[0] == cycle) begin
				check_value({fl_name_q[0], " flags"}, {28'b0, fl_val_q[0]}, {28'b0, flags});
				void'(fl_due_q.pop_front());
				void'(fl_val_q.pop_front());
				void'(fl_name_q.pop_front());
			end
		end
	end

	initial begin
		wait (limit > 0 && cycle >= limit);
		$display("timeout at cycle %0d, expected events never arrived", cycle);
		$display("errors: %0d value mismatches, %0d event errors", check_errors,
			event_errors + 1);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		rst = 1'b1;
		instr_valid = 1'b0;
		instr = 32'b0;
		pc = 32'b0;
		seed = seed_init;
		for (int i = 0; i < 16; i++)
			model_regs[i] = 32'b0;
		build_table();
		limit = reset_cycles + n_rows + n_random + 50;
		repeat (reset_cycles) @(posedge clk);
		rst <= 1'b0;
		for (int i = 0; i < n_rows; i++) begin
			issue_instr(row_name[i], row_instr[i], row_pc[i], row_has_wb[i], row_rd[i],
				row_data[i], row_has_br[i], row_target[i], row_has_ill[i],
				row_has_flags[i], row_flags[i]);
			if (row_has_wb[i])
				model_regs[row_rd[i]] = row_data[i];
		end
		next_pc = row_pc[n_rows-1] + 32'd4;
		run_random();
		@(posedge clk);
		instr_valid <= 1'b0;
		while (wb_due_q.size() + br_due_q.size() + ill_due_q.size() + fl_due_q.size() > 0)
			@(negedge clk);
		repeat (4) @(negedge clk); // catch any stray late event
		$display("errors: %0d value mismatches, %0d event errors", check_errors,
			event_errors);
		if (check_errors + event_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== verilog.f ====
verilog/cpu_pkg.sv
verilog/cpu_regfile.sv
verilog/cpu_decode.sv
verilog/cpu_execute.sv
verilog/cpu_result.sv
verilog/cpu_core.sv
verif/tb_clock.sv
verif/tb_cpu_core.sv

// ==== verilog/cpu_core.sv ====
`timescale 1ns/100ps

module cpu_core import cpu_pkg::*; (
	input logic clk,
	input logic rst,
	input logic instr_valid,
	input logic [31:0] instr,
	input logic [31:0] pc,
	output logic wb_valid,
	output logic [reg_sel_width-1:0] wb_rd,
	output logic [31:0] wb_data,
	output logic branch_taken,
	output logic [31:0] branch_target,
	output logic illegal,
	output logic [31:0] illegal_pc,
	output logic [3:0] flags
);

	logic [reg_sel_width-1:0] ra_sel;
	logic [reg_sel_width-1:0] rb_sel;
	logic [31:0] ra_val;
	logic [31:0] rb_val;
	logic wr_en;
	logic [reg_sel_width-1:0] wr_sel;
	logic [31:0] wr_data;

	logic d_valid;
	logic d_illegal;
	logic [reg_sel_width-1:0] rd_sel;
	logic update_rd;
	logic update_flags;
	logic [3:0] alu_opc;
	logic op2_imm;
	logic is_branch;
	logic is_call;
	logic [2:0] branch_condition;
	logic [31:0] imm32;
	logic [31:0] op1;
	logic [31:0] op2;
	logic [reg_sel_width-1:0] op1_sel;
	logic [reg_sel_width-1:0] op2_sel;
	logic [31:0] pc_plus_4;

	logic e_valid;
	logic e_illegal;
	logic [31:0] e_pc;
	logic e_update_rd;
	logic [reg_sel_width-1:0] e_rd;
	logic [31:0] e_result;

	cpu_regfile regfile_inst (
		.clk(clk), .rst(rst),
		.ra_sel(ra_sel), .rb_sel(rb_sel), .ra(ra_val), .rb(rb_val),
		.wr_en(wr_en), .wr_sel(wr_sel), .wr_data(wr_data)
	);

	cpu_decode decode_inst (
		.clk(clk), .rst(rst),
		.instr_valid(instr_valid), .instr(instr), .pc(pc),
		.ra_sel(ra_sel), .rb_sel(rb_sel), .ra_val(ra_val), .rb_val(rb_val),
		.d_valid(d_valid), .d_illegal(d_illegal), .rd_sel(rd_sel),
		.update_rd(update_rd), .update_flags(update_flags), .alu_opc(alu_opc),
		.op2_imm(op2_imm), .is_branch(is_branch), .is_call(is_call),
		.branch_condition(branch_condition), .imm32(imm32), .op1(op1), .op2(op2),
		.op1_sel(op1_sel), .op2_sel(op2_sel), .pc_plus_4_out(pc_plus_4)
	);

	cpu_execute execute_inst (
		.clk(clk), .rst(rst),
		.d_valid(d_valid), .d_illegal(d_illegal), .rd_sel(rd_sel),
		.update_rd(update_rd), .update_flags(update_flags), .alu_opc(alu_opc),
		.op2_imm(op2_imm), .is_branch(is_branch), .is_call(is_call),
		.branch_condition(branch_condition), .imm32(imm32), .op1(op1), .op2(op2),
		.op1_sel(op1_sel), .op2_sel(op2_sel), .pc_plus_4(pc_plus_4),
		.r_valid(wb_valid), .r_update_rd(wb_valid), .r_rd(wb_rd), .r_data(wb_data),
		.e_valid(e_valid), .e_illegal(e_illegal), .e_pc(e_pc),
		.e_update_rd(e_update_rd), .e_rd(e_rd), .e_result(e_result),
		.branch_taken(branch_taken), .branch_target(branch_target), .flags(flags)
	);

	// wb_valid only rises for real register writes, so it doubles as the update bit
	cpu_result result_inst (
		.clk(clk), .rst(rst),
		.e_valid(e_valid), .e_illegal(e_illegal), .e_pc(e_pc),
		.e_update_rd(e_update_rd), .e_rd(e_rd), .e_result(e_result),
		.wr_en(wr_en), .wr_sel(wr_sel), .wr_data(wr_data),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
		.illegal(illegal), .illegal_pc(illegal_pc)
	);

endmodule

// ==== verilog/cpu_decode.sv ====
`timescale 1ns/100ps

module cpu_decode import cpu_pkg::*; (
	input logic clk,
	input logic rst,
	input logic instr_valid,
	input logic [31:0] instr,
	input logic [31:0] pc,
	output logic [reg_sel_width-1:0] ra_sel,
	output logic [reg_sel_width-1:0] rb_sel,
	input logic [31:0] ra_val,
	input logic [31:0] rb_val,
	output logic d_valid,
	output logic d_illegal,
	output logic [reg_sel_width-1:0] rd_sel,
	output logic update_rd,
	output logic update_flags,
	output logic [3:0] alu_opc,
	output logic op2_imm,
	output logic is_branch,
	output logic is_call,
	output logic [2:0] branch_condition,
	output logic [31:0] imm32,
	output logic [31:0] op1,
	output logic [31:0] op2,
	output logic [reg_sel_width-1:0] op1_sel,
	output logic [reg_sel_width-1:0] op2_sel,
	output logic [31:0] pc_plus_4_out
);

	logic [uc_width-1:0] microcode [0:(1 << opc_width)-1];
	logic [opc_width-1:0] opcode;
	logic [uc_width-1:0] uc_val;
	logic valid;
	logic rd_is_lr;
	logic rd_as_op1;
	logic [1:0] imsel;
	logic [31:0] imm_next;

	initial begin
		$readmemh(rom_path, microcode);
	end

	assign opcode = instr[31:27];
	assign uc_val = microcode[opcode];

	// the core has no memory port, so a word asking for one is refused too
	assign valid = uc_val[uc_valid] & ~uc_val[uc_mem_load] & ~uc_val[uc_mem_store];
	assign rd_is_lr = uc_val[uc_rd_is_lr];
	assign imsel = uc_val[uc_imsel +: 2];

	// orlo reads its own rd through the rb port and uses it as operand 1
	assign rd_as_op1 = (uc_val[uc_alu_opc +: 4] == alu_orlo);

	assign ra_sel = instr[11:8];
	assign rb_sel = rd_as_op1 ? instr[3:0] : instr[7:4];

	always_comb begin
		case (imsel)
		imsel_imm13: imm_next = {{19{instr[24]}}, instr[24:12]};
		imsel_imm24: imm_next = {{6{instr[23]}}, instr[23:0], 2'b00}; // word offset
		imsel_hi16: imm_next = {instr[26:11], 16'b0};
		default: imm_next = {16'b0, instr[26:11]};
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			d_valid <= 1'b0;
			d_illegal <= 1'b0;
			update_rd <= 1'b0;
			update_flags <= 1'b0;
			is_branch <= 1'b0;
		end else begin
			d_valid <= instr_valid;
			d_illegal <= instr_valid & ~valid;
			// an invalid word must not touch registers, flags or control flow
			update_rd <= instr_valid & valid & uc_val[uc_update_rd];
			update_flags <= instr_valid & valid & uc_val[uc_update_flags];
			is_branch <= instr_valid & valid & uc_val[uc_is_branch];
		end
	end

	always_ff @(posedge clk) begin
		rd_sel <= rd_is_lr ? lr_reg : instr[3:0];
		alu_opc <= uc_val[uc_alu_opc +: 4];
		op2_imm <= uc_val[uc_op2_imm];
		is_call <= uc_val[uc_is_call];
		branch_condition <= uc_val[uc_branch_cond +: 3];
		imm32 <= imm_next;
		op1 <= rd_as_op1 ? rb_val : ra_val;
		op2 <= rb_val;
		op1_sel <= rd_as_op1 ? rb_sel : ra_sel; // execute forwards by these numbers
		op2_sel <= rb_sel;
		pc_plus_4_out <= pc + 32'd4;
	end

endmodule

// ==== verilog/cpu_execute.sv ====
`timescale 1ns/100ps

module cpu_execute import cpu_pkg::*; (
	input logic clk,
	input logic rst,
	input logic d_valid,
	input logic d_illegal,
	input logic [reg_sel_width-1:0] rd_sel,
	input logic update_rd,
	input logic update_flags,
	input logic [3:0] alu_opc,
	input logic op2_imm,
	input logic is_branch,
	input logic is_call,
	input logic [2:0] branch_condition,
	input logic [31:0] imm32,
	input logic [31:0] op1,
	input logic [31:0] op2,
	input logic [reg_sel_width-1:0] op1_sel,
	input logic [reg_sel_width-1:0] op2_sel,
	input logic [31:0] pc_plus_4,
	input logic r_valid,
	input logic r_update_rd,
	input logic [reg_sel_width-1:0] r_rd,
	input logic [31:0] r_data,
	output logic e_valid,
	output logic e_illegal,
	output logic [31:0] e_pc,
	output logic e_update_rd,
	output logic [reg_sel_width-1:0] e_rd,
	output logic [31:0] e_result,
	output logic branch_taken,
	output logic [31:0] branch_target,
	output logic [3:0] flags
);

	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] rb_fwd;
	logic [31:0] alu_out;
	logic [32:0] add_full;
	logic [32:0] sub_full;
	logic add_ovf;
	logic sub_ovf;
	logic is_sub;
	logic cond_met;
	logic [3:0] next_flags;

	// the instruction one ahead wins over the one two ahead
	function automatic logic [31:0] forward(input logic [reg_sel_width-1:0] sel,
						input logic [31:0] val);
		if (e_valid && e_update_rd && e_rd == sel)
			return e_result;
		else if (r_valid && r_update_rd && r_rd == sel)
			return r_data;
		return val;
	endfunction

	always_comb begin
		a = forward(op1_sel, op1);
		rb_fwd = forward(op2_sel, op2);
	end

	assign b = op2_imm ? imm32 : rb_fwd;

	assign add_full = {1'b0, a} + {1'b0, b};
	assign sub_full = {1'b0, a} + {1'b0, ~b} + 33'd1; // bit 32 set means no borrow
	assign add_ovf = (a[31] == b[31]) && (add_full[31] != a[31]);
	assign sub_ovf = (a[31] != b[31]) && (sub_full[31] != a[31]);
	assign is_sub = (alu_opc == alu_sub);

	always_comb begin
		case (alu_opc)
		alu_add: alu_out = add_full[31:0];
		alu_sub: alu_out = sub_full[31:0];
		alu_and: alu_out = a & b;
		alu_or: alu_out = a | b;
		alu_xor: alu_out = a ^ b;
		alu_shl: alu_out = a << b[4:0];
		alu_shr: alu_out = a >> b[4:0]; // logical
		alu_movb: alu_out = b;
		alu_orlo: alu_out = a | {16'b0, b[15:0]};
		default: alu_out = 32'b0;
		endcase
	end

	always_comb begin
		next_flags[flag_z] = (alu_out == 32'b0);
		next_flags[flag_n] = alu_out[31];
		next_flags[flag_c] = is_sub ? sub_full[32] : add_full[32];
		next_flags[flag_v] = is_sub ? sub_ovf : add_ovf;
	end

	// conditions look at the flags left by earlier instructions
	always_comb begin
		case (branch_condition)
		cond_always: cond_met = 1'b1;
		cond_eq: cond_met = flags[flag_z];
		cond_ne: cond_met = ~flags[flag_z];
		cond_lt: cond_met = flags[flag_n] ^ flags[flag_v];
		cond_ge: cond_met = ~(flags[flag_n] ^ flags[flag_v]);
		cond_ult: cond_met = ~flags[flag_c];
		default: cond_met = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			e_valid <= 1'b0;
			e_illegal <= 1'b0;
			e_update_rd <= 1'b0;
			branch_taken <= 1'b0;
			flags <= 4'b0;
		end else begin
			e_valid <= d_valid;
			e_illegal <= d_valid & d_illegal;
			e_update_rd <= d_valid & update_rd;
			branch_taken <= d_valid & is_branch & cond_met; // one cycle pulse
			if (d_valid && update_flags)
				flags <= next_flags;
		end
	end

	always_ff @(posedge clk) begin
		e_rd <= rd_sel;
		e_result <= is_call ? pc_plus_4 : alu_out; // call links the return address
		e_pc <= pc_plus_4 - 32'd4;
		branch_target <= pc_plus_4 + imm32;
	end

endmodule

// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

	// opcode is instr[31:27], so the ROM has 32 entries
	localparam int opc_width = 5;

	// the two reserved memory bits sit above the valid bit
	localparam int uc_width = 18;

	// microcode field positions, lsb of each field
	localparam int uc_alu_opc = 0; // 4 bits
	localparam int uc_op2_imm = 4;
	localparam int uc_update_flags = 5;
	localparam int uc_update_rd = 6;
	localparam int uc_branch_cond = 7; // 3 bits
	localparam int uc_is_branch = 10;
	localparam int uc_is_call = 11;
	localparam int uc_rd_is_lr = 12;
	localparam int uc_imsel = 13; // 2 bits
	localparam int uc_valid = 15;
	localparam int uc_mem_load = 16;
	localparam int uc_mem_store = 17;

	localparam logic [1:0] imsel_imm13 = 2'd0;
	localparam logic [1:0] imsel_imm24 = 2'd1;
	localparam logic [1:0] imsel_hi16 = 2'd2;
	localparam logic [1:0] imsel_lo16 = 2'd3;

	localparam int reg_sel_width = 4;
	localparam logic [reg_sel_width-1:0] lr_reg = 4'd15; // link register for calls

	localparam logic [3:0] alu_add = 4'd0;
	localparam logic [3:0] alu_sub = 4'd1;
	localparam logic [3:0] alu_and = 4'd2;
	localparam logic [3:0] alu_or = 4'd3;
	localparam logic [3:0] alu_xor = 4'd4;
	localparam logic [3:0] alu_shl = 4'd5;
	localparam logic [3:0] alu_shr = 4'd6;
	localparam logic [3:0] alu_movb = 4'd7; // pass operand 2
	localparam logic [3:0] alu_orlo = 4'd8; // low half or'd into rd

	localparam logic [2:0] cond_always = 3'd0;
	localparam logic [2:0] cond_eq = 3'd1;
	localparam logic [2:0] cond_ne = 3'd2;
	localparam logic [2:0] cond_lt = 3'd3; // signed
	localparam logic [2:0] cond_ge = 3'd4; // signed
	localparam logic [2:0] cond_ult = 3'd5;

	localparam int flag_z = 0;
	localparam int flag_n = 1;
	localparam int flag_c = 2;
	localparam int flag_v = 3;

	localparam logic [opc_width-1:0] op_add = 5'd0;
	localparam logic [opc_width-1:0] op_sub = 5'd1;
	localparam logic [opc_width-1:0] op_and = 5'd2;
	localparam logic [opc_width-1:0] op_or = 5'd3;
	localparam logic [opc_width-1:0] op_xor = 5'd4;
	localparam logic [opc_width-1:0] op_shl = 5'd5;
	localparam logic [opc_width-1:0] op_shr = 5'd6;
	localparam logic [opc_width-1:0] op_addi = 5'd7;
	localparam logic [opc_width-1:0] op_subi = 5'd8;
	localparam logic [opc_width-1:0] op_cmp = 5'd9;
	localparam logic [opc_width-1:0] op_movhi = 5'd10;
	localparam logic [opc_width-1:0] op_orlo = 5'd11;
	// each branch opcode carries its own condition in the microcode
	localparam logic [opc_width-1:0] op_b = 5'd12; // always
	localparam logic [opc_width-1:0] op_beq = 5'd13;
	localparam logic [opc_width-1:0] op_bne = 5'd14;
	localparam logic [opc_width-1:0] op_blt = 5'd15;
	localparam logic [opc_width-1:0] op_bge = 5'd16;
	localparam logic [opc_width-1:0] op_bult = 5'd17;
	localparam logic [opc_width-1:0] op_call = 5'd18;

	localparam string rom_path = "decode.hex";

endpackage

// ==== verilog/cpu_regfile.sv ====
`timescale 1ns/100ps

module cpu_regfile import cpu_pkg::*; (
	input logic clk,
	input logic rst,
	input logic [reg_sel_width-1:0] ra_sel,
	input logic [reg_sel_width-1:0] rb_sel,
	output logic [31:0] ra,
	output logic [31:0] rb,
	input logic wr_en,
	input logic [reg_sel_width-1:0] wr_sel,
	input logic [31:0] wr_data
);

	logic [31:0] regs [0:(1 << reg_sel_width)-1];
	logic ra_hit;
	logic rb_hit;

	// a read of the register being written sees the new value
	assign ra_hit = wr_en && (wr_sel == ra_sel);
	assign rb_hit = wr_en && (wr_sel == rb_sel);

	assign ra = ra_hit ? wr_data : regs[ra_sel];
	assign rb = rb_hit ? wr_data : regs[rb_sel];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < (1 << reg_sel_width); i++)
				regs[i] <= 32'b0;
		end else if (wr_en) begin
			regs[wr_sel] <= wr_data;
		end
	end

endmodule

// ==== verilog/cpu_result.sv ====
`timescale 1ns/100ps

module cpu_result import cpu_pkg::*; (
	input logic clk,
	input logic rst,
	input logic e_valid,
	input logic e_illegal,
	input logic [31:0] e_pc,
	input logic e_update_rd,
	input logic [reg_sel_width-1:0] e_rd,
	input logic [31:0] e_result,
	output logic wr_en,
	output logic [reg_sel_width-1:0] wr_sel,
	output logic [31:0] wr_data,
	output logic wb_valid,
	output logic [reg_sel_width-1:0] wb_rd,
	output logic [31:0] wb_data,
	output logic illegal,
	output logic [31:0] illegal_pc
);

	// the regfile takes the write on the same edge that raises wb_valid
	assign wr_en = e_valid & e_update_rd & ~e_illegal;
	assign wr_sel = e_rd;
	assign wr_data = e_result;

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid <= 1'b0;
			illegal <= 1'b0;
		end else begin
			wb_valid <= wr_en;
			illegal <= e_valid & e_illegal;
		end
	end

	// wb_rd and wb_data also feed execute's two-ahead forwarding
	always_ff @(posedge clk) begin
		wb_rd <= e_rd;
		wb_data <= e_result;
		illegal_pc <= e_pc;
	end

endmodule
